//--- memPkg.sv
`default_nettype none

package memPkg;

    // byte address and data word widths
    localparam int ADDR_W = 16;
    localparam int WORD_W = 32;

    // access length codes
    typedef logic [1:0] len_t;

    localparam len_t LEN_B = 2'd0;
    localparam len_t LEN_H = 2'd1;
    localparam len_t LEN_W = 2'd2;

    // data port request
    typedef struct packed {
        logic              write;
        len_t              len;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } memReq_t;

    // one byte access on the ram
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } ramPort_t;

    // instruction queue entry
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [WORD_W-1:0] inst;
    } fetchEntry_t;

    // byte count of a length code, unused code taken as a word
    function automatic logic [2:0] lenBytes(input len_t len);
        case (len)
            LEN_B:   return 3'd1;
            LEN_H:   return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
    parameter int RAM_BYTES = 4096
) (
    input  logic             clk,
    input  memPkg::ramPort_t i_port,
    output logic [7:0]       o_rdata
);

    localparam int IDX_W = (RAM_BYTES > 1) ? $clog2(RAM_BYTES) : 1;

    logic [7:0]       mem [RAM_BYTES];
    logic [IDX_W-1:0] idx;

    // upper address bits are ignored, the space wraps
    assign idx = i_port.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (i_port.we) begin
            mem[idx] <= i_port.wdata;
        end
        // read data comes out one cycle later
        o_rdata <= mem[idx];
    end

endmodule

`default_nettype wire

//--- memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_rdy,
    input  logic                       i_dataReq,
    input  memPkg::memReq_t            i_dataReqInfo,
    input  logic                       i_fetchReq,
    input  logic [memPkg::ADDR_W-1:0]  i_fetchAddr,
    input  logic                       i_flush,
    input  logic [7:0]                 i_rdata,
    output logic                       o_dataBusy,
    output logic                       o_dataDone,
    output logic [memPkg::WORD_W-1:0]  o_loadData,
    output logic                       o_fetchBusy,
    output logic                       o_fetchDone,
    output memPkg::fetchEntry_t        o_fetchEntry,
    output memPkg::ramPort_t           o_ram
);

    import memPkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD,
        ST_WR,
        ST_RI
    } state_t;

    state_t            state;
    logic [2:0]        stage;
    logic [2:0]        nBytes;
    logic [2:0]        ramIdx;
    logic              readLast;
    logic              writeLast;
    logic              dropFetch;

    logic [ADDR_W-1:0] capAddr;
    len_t              capLen;
    logic [WORD_W-1:0] capWdata;
    logic [23:0]       asmReg;
    logic [WORD_W-1:0] asmWord;

    assign nBytes    = lenBytes(capLen);
    assign readLast  = (state == ST_RD || state == ST_RI) && stage == nBytes;
    assign writeLast = state == ST_WR && stage == nBytes - 3'd1;

    // last byte comes straight from the ram, earlier ones from asmReg
    assign asmWord = {i_rdata, asmReg} >> {3'd4 - nBytes, 3'b000};

    assign o_dataBusy  = state != ST_IDLE;
    // a data strobe takes the idle slot, so fetch must wait
    assign o_fetchBusy = state != ST_IDLE || i_dataReq;

    assign o_dataDone   = i_rdy && ((state == ST_RD && readLast) || writeLast);
    assign o_loadData   = asmWord;
    assign o_fetchDone  = i_rdy && state == ST_RI && readLast && !dropFetch && !i_flush;
    assign o_fetchEntry = '{pc: capAddr, inst: asmWord};

    // byte offset presented to the ram
    // on a stall or after the last byte, re-read the previous byte so rdata holds
    always_comb begin
        if (stage == 3'd0) begin
            ramIdx = 3'd0;
        end else if (!i_rdy || stage == nBytes) begin
            ramIdx = stage - 3'd1;
        end else begin
            ramIdx = stage;
        end
    end

    always_comb begin
        o_ram.we    = state == ST_WR && i_rdy;
        o_ram.addr  = capAddr + ADDR_W'(ramIdx);
        o_ram.wdata = capWdata[7:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            stage     <= 3'd0;
            dropFetch <= 1'b0;
        end else if (i_rdy) begin
            case (state)
                ST_IDLE: begin
                    stage     <= 3'd0;
                    dropFetch <= 1'b0;
                    // data port has priority
                    if (i_dataReq) begin
                        state <= i_dataReqInfo.write ? ST_WR : ST_RD;
                    end else if (i_fetchReq) begin
                        state <= ST_RI;
                    end
                end
                ST_RD, ST_RI: begin
                    if (readLast) begin
                        state     <= ST_IDLE;
                        stage     <= 3'd0;
                        dropFetch <= 1'b0;
                    end else begin
                        stage <= stage + 3'd1;
                        if (state == ST_RI && i_flush) begin
                            dropFetch <= 1'b1;
                        end
                    end
                end
                ST_WR: begin
                    if (writeLast) begin
                        state <= ST_IDLE;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    stage <= 3'd0;
                end
            endcase
        end
    end

    // request capture and byte shifting
    always_ff @(posedge clk) begin
        if (i_rdy) begin
            case (state)
                ST_IDLE: begin
                    if (i_dataReq) begin
                        capAddr  <= i_dataReqInfo.addr;
                        capLen   <= i_dataReqInfo.len;
                        capWdata <= i_dataReqInfo.wdata;
                    end else if (i_fetchReq) begin
                        capAddr <= i_fetchAddr;
                        capLen  <= LEN_W;
                    end
                end
                ST_RD, ST_RI: begin
                    if (stage != 3'd0) begin
                        asmReg <= {i_rdata, asmReg[23:8]};
                    end
                end
                ST_WR: begin
                    capWdata <= capWdata >> 8;
                end
                default: begin
                    asmReg <= asmReg;
                end
            endcase
        end
    end

    // a load never writes the ram before its done pulse
    assert property (@(posedge clk) disable iff (rst)
        state == ST_IDLE && i_rdy && i_dataReq && !i_dataReqInfo.write
        |=> !o_ram.we until_with o_dataDone);

    // requesters respect the busy flags
    assert property (@(posedge clk) disable iff (rst) i_dataReq |-> !o_dataBusy);
    assert property (@(posedge clk) disable iff (rst) i_fetchReq |-> !o_fetchBusy);

endmodule

`default_nettype wire

//--- fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
    parameter int                         QUEUE_DEPTH = 4,
    parameter logic [memPkg::ADDR_W-1:0]  START_PC    = '0
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_rdy,
    input  logic                               i_fetchEn,
    input  logic                               i_redirect,
    input  logic [memPkg::ADDR_W-1:0]          i_redirectPc,
    input  logic                               i_fetchBusy,
    input  logic                               i_fetchDone,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   i_queueCount,
    output logic                               o_fetchReq,
    output logic [memPkg::ADDR_W-1:0]          o_fetchAddr
);

    import memPkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [ADDR_W-1:0] pc;
    logic              inFlight;
    logic [CNT_W:0]    used;
    logic              room;
    logic              issue;

    // entries already queued plus the one on its way
    assign used  = {1'b0, i_queueCount} + (CNT_W + 1)'(inFlight);
    assign room  = used < QUEUE_DEPTH;
    assign issue = i_rdy && i_fetchEn && !i_redirect && !i_fetchBusy && room;

    assign o_fetchReq  = issue;
    assign o_fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= START_PC;
            inFlight <= 1'b0;
        end else if (i_rdy) begin
            if (i_redirect) begin
                // old fetch is dropped by the controller
                pc       <= i_redirectPc;
                inFlight <= 1'b0;
            end else if (issue) begin
                pc       <= pc + ADDR_W'(4);
                inFlight <= 1'b1;
            end else if (i_fetchDone) begin
                inFlight <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- instQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_rdy,
    input  logic                              i_flush,
    input  logic                              i_push,
    input  memPkg::fetchEntry_t               i_pushEntry,
    input  logic                              i_pop,
    output logic                              o_valid,
    output memPkg::fetchEntry_t               o_head,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]  o_count
);

    import memPkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    fetchEntry_t      entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             doPush;
    logic             doPop;

    assign full    = count == CNT_W'(QUEUE_DEPTH);
    assign doPush  = i_rdy && i_push && !i_flush;
    assign doPop   = i_rdy && i_pop && o_valid && !i_flush;

    assign o_valid = count != '0;
    assign o_head  = entries[rdPtr];
    assign o_count = count;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (i_rdy) begin
            if (i_flush) begin
                rdPtr <= '0;
                wrPtr <= '0;
                count <= '0;
            end else begin
                if (doPush) begin
                    wrPtr <= nextPtr(wrPtr);
                end
                if (doPop) begin
                    rdPtr <= nextPtr(rdPtr);
                end
                case ({doPush, doPop})
                    2'b10:   count <= count + CNT_W'(1);
                    2'b01:   count <= count - CNT_W'(1);
                    default: count <= count;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= i_pushEntry;
        end
    end

    // fetch issue must leave a free slot for every returning word
    assert property (@(posedge clk) disable iff (rst) i_push |-> !full);

endmodule

`default_nettype wire

//--- memSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsys #(
    parameter int                         RAM_BYTES   = 4096,
    parameter int                         QUEUE_DEPTH = 4,
    parameter logic [memPkg::ADDR_W-1:0]  START_PC    = '0
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_rdy,
    input  logic                              i_fetchEn,
    input  logic                              i_redirect,
    input  logic [memPkg::ADDR_W-1:0]         i_redirectPc,
    input  logic                              i_dataReq,
    input  memPkg::memReq_t                   i_dataReqInfo,
    input  logic                              i_instPop,
    output logic                              o_dataBusy,
    output logic                              o_dataDone,
    output logic [memPkg::WORD_W-1:0]         o_loadData,
    output logic                              o_instValid,
    output memPkg::fetchEntry_t               o_instHead
);

    import memPkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic              fetchReq;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchBusy;
    logic              fetchDone;
    fetchEntry_t       fetchEntry;
    ramPort_t          ramPort;
    logic [7:0]        ramRdata;
    logic [CNT_W-1:0]  queueCount;

    fetchUnit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .START_PC    (START_PC)
    ) uFetch (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_fetchEn    (i_fetchEn),
        .i_redirect   (i_redirect),
        .i_redirectPc (i_redirectPc),
        .i_fetchBusy  (fetchBusy),
        .i_fetchDone  (fetchDone),
        .i_queueCount (queueCount),
        .o_fetchReq   (fetchReq),
        .o_fetchAddr  (fetchAddr)
    );

    memCtrl uCtrl (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_dataReq     (i_dataReq),
        .i_dataReqInfo (i_dataReqInfo),
        .i_fetchReq    (fetchReq),
        .i_fetchAddr   (fetchAddr),
        .i_flush       (i_redirect),
        .i_rdata       (ramRdata),
        .o_dataBusy    (o_dataBusy),
        .o_dataDone    (o_dataDone),
        .o_loadData    (o_loadData),
        .o_fetchBusy   (fetchBusy),
        .o_fetchDone   (fetchDone),
        .o_fetchEntry  (fetchEntry),
        .o_ram         (ramPort)
    );

    byteRam #(
        .RAM_BYTES (RAM_BYTES)
    ) uRam (
        .clk     (clk),
        .i_port  (ramPort),
        .o_rdata (ramRdata)
    );

    // fetch done is the queue push
    instQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uQueue (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_flush     (i_redirect),
        .i_push      (fetchDone),
        .i_pushEntry (fetchEntry),
        .i_pop       (i_instPop),
        .o_valid     (o_instValid),
        .o_head      (o_instHead),
        .o_count     (queueCount)
    );

endmodule

`default_nettype wire

//--- tb_memSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memSubsys;

    import memPkg::*;

    localparam int RAM_BYTES   = 4096;
    localparam int QUEUE_DEPTH = 4;
    // high cycles allowed for the queue to fill after a redirect
    localparam int FILL_WAIT   = 40;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              fetchEn;
    logic              redirect;
    logic [ADDR_W-1:0] redirectPc;
    logic              dataReq;
    memReq_t           dataReqInfo;
    logic              instPop;
    logic              dataBusy;
    logic              dataDone;
    logic [WORD_W-1:0] loadData;
    logic              instValid;
    fetchEntry_t       instHead;

    logic [7:0]        shadow [RAM_BYTES];
    logic [7:0]        opQ [$];
    logic [ADDR_W-1:0] addrQ [$];
    int                lenQ [$];
    logic [31:0]       dataQ [$];
    int                cntQ [$];

    int                errCnt;
    int                checkCnt;
    int                cycleCnt;
    int                cycleLimit = 0;
    bit                gapsOn;
    logic [ADDR_W-1:0] expPc;

    memSubsys #(
        .RAM_BYTES   (RAM_BYTES),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .START_PC    ('0)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (rdy),
        .i_fetchEn     (fetchEn),
        .i_redirect    (redirect),
        .i_redirectPc  (redirectPc),
        .i_dataReq     (dataReq),
        .i_dataReqInfo (dataReqInfo),
        .i_instPop     (instPop),
        .o_dataBusy    (dataBusy),
        .o_dataDone    (dataDone),
        .o_loadData    (loadData),
        .o_instValid   (instValid),
        .o_instHead    (instHead)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycleCnt = 0;
        wait (cycleLimit != 0);
        while (cycleCnt < cycleLimit) begin
            @(posedge clk);
            cycleCnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic checkVal(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
        checkCnt++;
        if (actual !== expected) begin
            errCnt++;
            $display("** Error at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    // expected instruction word in little-endian order
    function automatic logic [31:0] shadowWord(input logic [ADDR_W-1:0] addr);
        return {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    endfunction

    function automatic len_t lenCode(input int nBytes);
        case (nBytes)
            1:       return LEN_B;
            2:       return LEN_H;
            default: return LEN_W;
        endcase
    endfunction

    // step one cycle and drop the strobes
    // rdy goes randomly low once gaps are on
    task automatic advance(input bit forceRdy);
        @(posedge clk);
        #10;
        dataReq  = 1'b0;
        redirect = 1'b0;
        instPop  = 1'b0;
        if (forceRdy || !gapsOn) begin
            rdy = 1'b1;
        end else begin
            rdy = ($urandom % 4) != 0;
        end
    endtask

    task automatic readStim(output bit ok);
        int               fd;
        int               n;
        logic [7:0]       ch;
        logic [ADDR_W-1:0] a;
        int               l;
        logic [31:0]      d;
        int               c;
        logic [8*160-1:0] skipLine;
        fd = $fopen("memSubsys_stim.txt", "r");
        ok = fd != 0;
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", ch);
            if (n != 1) begin
                break;
            end
            if (ch == "#") begin
                n = $fgets(skipLine, fd);
            end else begin
                n = $fscanf(fd, "%h %d %h %d", a, l, d, c);
                if (n != 4) begin
                    errCnt++;
                    $display("stimulus line for op %c has missing fields", ch);
                end
                opQ.push_back(ch);
                addrQ.push_back(a);
                lenQ.push_back(l);
                dataQ.push_back(d);
                cntQ.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    function automatic int estimateCycles();
        int total;
        total = 4;
        foreach (opQ[i]) begin
            case (opQ[i])
                "S", "L": total += lenQ[i] + 8;
                "R":      total += FILL_WAIT + 4 + 10 * cntQ[i];
                "P":      total += 10 * cntQ[i];
                default:  total += cntQ[i] + 1;
            endcase
        end
        return total;
    endfunction

    task automatic dataAccess(input bit isWrite, input logic [ADDR_W-1:0] addr,
                              input int nBytes, input logic [31:0] data);
        int expLat;
        int highCnt;
        int i;
        expLat  = isWrite ? nBytes : nBytes + 1;
        highCnt = 0;
        do begin
            advance(1'b0);
        end while (dataBusy);
        rdy               = 1'b1;
        dataReq           = 1'b1;
        dataReqInfo.write = isWrite;
        dataReqInfo.len   = lenCode(nBytes);
        dataReqInfo.addr  = addr;
        dataReqInfo.wdata = isWrite ? data : 32'h0;
        if (isWrite) begin
            for (i = 0; i < nBytes; i++) begin
                shadow[addr + i] = data[8*i +: 8];
            end
        end
        // latency counted in cycles with rdy high
        do begin
            advance(1'b0);
            @(negedge clk);
            if (rdy) begin
                highCnt++;
            end
        end while (!dataDone && highCnt < expLat + 3);
        checkVal("o_dataDone latency", highCnt, expLat);
        if (!isWrite && dataDone) begin
            checkVal("o_loadData", loadData, data);
        end
    endtask

    task automatic popEntries(input int count);
        int n;
        for (n = 0; n < count; n++) begin
            repeat ($urandom % 4) advance(1'b0);
            do begin
                advance(1'b0);
            end while (!instValid);
            rdy     = 1'b1;
            instPop = 1'b1;
            @(negedge clk);
            checkVal("o_instHead.pc", instHead.pc, expPc);
            checkVal("o_instHead.inst", instHead.inst, shadowWord(expPc));
            expPc += 4;
        end
    endtask

    task automatic redirectFetch(input logic [ADDR_W-1:0] addr, input int count);
        int highCnt;
        // two cycles so a refill fetch is usually in flight
        advance(1'b0);
        advance(1'b0);
        rdy        = 1'b1;
        redirect   = 1'b1;
        redirectPc = addr;
        fetchEn    = 1'b1;
        expPc      = addr;
        highCnt    = 0;
        while (highCnt < FILL_WAIT) begin
            advance(1'b0);
            if (rdy) begin
                highCnt++;
            end
        end
        @(negedge clk);
        checkVal("queue count", dut.uQueue.o_count, QUEUE_DEPTH);
        popEntries(count);
    endtask

    task automatic holdRdy(input int count);
        logic validBefore;
        logic busyBefore;
        int   n;
        validBefore = 1'b0;
        busyBefore  = 1'b0;
        for (n = 0; n < count; n++) begin
            advance(1'b0);
            rdy = 1'b0;
            if (n == 0) begin
                validBefore = instValid;
                busyBefore  = dataBusy;
            end
            @(negedge clk);
            // a fetch in flight freezes with everything else
            checkVal("o_dataBusy", dataBusy, busyBefore);
            checkVal("o_instValid", instValid, validBefore);
        end
        gapsOn = 1'b1;
    endtask

    initial begin
        bit ok;
        int seedSink;
        int i;
        seedSink    = $urandom(50160);
        errCnt      = 0;
        checkCnt    = 0;
        rst         = 1'b1;
        rdy         = 1'b1;
        fetchEn     = 1'b0;
        redirect    = 1'b0;
        redirectPc  = '0;
        dataReq     = 1'b0;
        dataReqInfo = '0;
        instPop     = 1'b0;
        gapsOn      = 1'b0;
        expPc       = '0;
        readStim(ok);
        if (ok) begin
            cycleLimit = 10 * estimateCycles();
        end else begin
            errCnt++;
            $display("could not open the stimulus file memSubsys_stim.txt");
        end
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        checkVal("o_dataBusy", dataBusy, 1'b0);
        checkVal("o_dataDone", dataDone, 1'b0);
        checkVal("o_instValid", instValid, 1'b0);
        for (i = 0; i < opQ.size(); i++) begin
            case (opQ[i])
                "S": dataAccess(1'b1, addrQ[i], lenQ[i], dataQ[i]);
                "L": dataAccess(1'b0, addrQ[i], lenQ[i], dataQ[i]);
                "R": redirectFetch(addrQ[i], cntQ[i]);
                "P": popEntries(cntQ[i]);
                "H": holdRdy(cntQ[i]);
                default: begin
                    errCnt++;
                    $display("unknown stimulus op %c on entry %0d", opQ[i], i);
                end
            endcase
        end
        advance(1'b1);
        advance(1'b1);
        $display("%0d checks run, %0d errors", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- memSubsys_stim.txt
# op addr(hex) len(bytes) data(hex) count
# S store, L load with expected data, R redirect and pop count, P pop more, H rdy low count
S 0100 4 13579bdf 0
S 0104 4 2468ace0 0
S 0108 4 0badf00d 0
S 010c 4 deadbeef 0
S 0110 2 00001234 0
S 0112 1 00000056 0
S 0113 1 00000078 0
S 0114 4 cafef00d 0
S 0118 4 01020304 0
S 011c 4 a5a55a5a 0
S 0120 4 76543210 0
S 0124 4 0f1e2d3c 0
S 0200 4 fedcba98 0
S 0204 4 31415926 0
L 0110 4 78561234 0
L 0112 2 00007856 0
L 0101 1 0000009b 0
L 0106 2 00002468 0
R 0100 0 00000000 3
S 0800 4 11223344 0
L 0800 4 11223344 0
L 0802 1 00000022 0
P 0000 0 00000000 4
R 0200 0 00000000 1
R 0108 0 00000000 3
H 0000 0 00000000 6
S 0804 2 0000beef 0
S 0805 1 00000077 0
L 0804 2 000077ef 0
L 0100 4 13579bdf 0
R 0114 0 00000000 4
P 0000 0 00000000 1
L 0124 4 0f1e2d3c 0

//--- src.f
memPkg.sv
byteRam.sv
memCtrl.sv
fetchUnit.sv
instQueue.sv
memSubsys.sv
tb_memSubsys.sv
